//--- include/coreSettings.svh
/*
 * Core settings
 * Reset address, data width and register count of the RV32I core
 */
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// First fetch address after reset
`define CORE_RESET_ADDR 32'h0000_0000

`define CORE_XLEN  32  // Data and address width
`define CORE_NREGS 32  // x0 to x31

`endif

//--- design/rvIsaPkg.sv
/*
 * RV32I ISA types
 * Major opcode on bits 6:2 and the funct3 encodings for ALU,
 * branch and memory access width
 */
package rvIsaPkg;

   // Base opcodes kept by the core, bits 6:2 of the instruction
   typedef enum logic [4:0] {
      load   = 5'b00000,  // rd <- mem[rs1+I]
      opImm  = 5'b00100,  // rd <- rs1 OP I
      auipc  = 5'b00101,  // rd <- PC+U
      store  = 5'b01000,  // mem[rs1+S] <- rs2
      op     = 5'b01100,  // rd <- rs1 OP rs2
      lui    = 5'b01101,  // rd <- U
      branch = 5'b11000,
      jalr   = 5'b11001,
      jal    = 5'b11011
   } opcodeT;

   // ALU funct3, bit 30 splits add/sub and srl/sra
   typedef enum logic [2:0] {
      aluAdd = 3'd0, aluSll = 3'd1, aluSlt = 3'd2, aluSltu = 3'd3,
      aluXor = 3'd4, aluSr  = 3'd5, aluOr  = 3'd6, aluAnd  = 3'd7
   } aluFnT;

   // Branch funct3, codes 2 and 3 are not defined
   typedef enum logic [2:0] {
      brEq = 3'd0, brNe = 3'd1, brLt = 3'd4, brGe = 3'd5, brLtu = 3'd6, brGeu = 3'd7
   } branchFnT;

   // Access width from funct3[1:0], funct3[2] is the unsigned flag for loads
   typedef enum logic [1:0] {memByte = 2'd0, memHalf = 2'd1, memWord = 2'd2} memWidthT;

endpackage

//--- design/coreTypesPkg.sv
/*
 * Core micro-architecture types
 * Control FSM states, data word and register index
 */
`include "coreSettings.svh"

package coreTypesPkg;

   // Multicycle control, one instruction in flight
   typedef enum logic [1:0] {
      fetchInstr = 2'd0,  // Read strobe with PC
      waitInstr  = 2'd1,  // Wait for instruction word
      execute    = 2'd2,  // Write back, update PC, start load/store
      waitMem    = 2'd3   // Wait until both busy flags drop
   } coreStateT;

   // Data and address word
   typedef logic [`CORE_XLEN-1:0] wordT;

   // Register index
   typedef logic [$clog2(`CORE_NREGS)-1:0] regIdxT;

endpackage

//--- design/operandIf.sv
/*
 * Operand bundle
 * Decoded fields and register operands for the execution units
 */
`timescale 1ns/1ps

interface operandIf
   import coreTypesPkg::*, rvIsaPkg::*;
();
   wordT       rs1Val;  // Latched while the instruction is fetched
   wordT       rs2Val;
   wordT       imm;     // Single immediate, format picked by opcode
   logic [2:0] funct3;
   logic       altFn;   // Instruction bit 30
   opcodeT     opcode;
   regIdxT     rdIdx;
   regIdxT     rs1Idx;
   regIdxT     rs2Idx;

   modport decode (output imm, funct3, altFn, opcode, rdIdx, rs1Idx, rs2Idx);
   modport regs   (output rs1Val, rs2Val, input rdIdx, rs1Idx, rs2Idx);
   modport exec   (input rs1Val, rs2Val, imm, funct3, altFn, opcode);
   modport ctrl   (input opcode, imm);
endinterface

//--- design/instrDecoder.sv
/*
 * Instruction decoder
 * Splits the latched instruction into opcode class, register
 * indices and funct fields, and builds the one immediate it needs
 */
`timescale 1ns/1ps

module instrDecoder
   import coreTypesPkg::*, rvIsaPkg::*;
(
   input  wordT      instr,  // Latched instruction word
   operandIf.decode  ops
);
   wordT iImm;
   wordT sImm;
   wordT bImm;
   wordT uImm;
   wordT jImm;

   // Plain field extraction
   assign ops.rdIdx  = instr[11:7];
   assign ops.rs1Idx = instr[19:15];
   assign ops.rs2Idx = instr[24:20];
   assign ops.funct3 = instr[14:12];
   assign ops.altFn  = instr[30];    // SUB and SRA select
   assign ops.opcode = opcodeT'(instr[6:2]);

   // Immediate formats, all sign-extended from bit 31
   assign iImm = {{21{instr[31]}}, instr[30:20]};
   assign sImm = {{21{instr[31]}}, instr[30:25], instr[11:7]};
   assign bImm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
   assign uImm = {instr[31:12], 12'b0};
   assign jImm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

   // One immediate per class
   always_comb begin
      case (ops.opcode)
         store:      ops.imm = sImm;
         branch:     ops.imm = bImm;
         lui, auipc: ops.imm = uImm;
         jal:        ops.imm = jImm;
         default:    ops.imm = iImm;  // opImm, load, jalr
      endcase
   end

endmodule

//--- design/regFile.sv
/*
 * Register file
 * 32 words, two synchronous read ports latched on regRead, one write port
 */
`timescale 1ns/1ps
`include "coreSettings.svh"

module regFile
   import coreTypesPkg::*;
(
   input  logic   clk,
   input  logic   regRead,  // Latch operands of the incoming word
   input  regIdxT rs1Sel,
   input  regIdxT rs2Sel,
   input  logic   wbEn,
   input  wordT   wbData,
   operandIf.regs ops
);
   wordT regs [`CORE_NREGS];

   // Writes to x0 are dropped
   always_ff @(posedge clk) begin
      if (wbEn && (ops.rdIdx != '0)) begin
         regs[ops.rdIdx] <= wbData;
      end
   end

   // x0 forced to zero on the read side
   always_ff @(posedge clk) begin
      if (regRead) begin
         ops.rs1Val <= (rs1Sel == '0) ? '0 : regs[rs1Sel];
         ops.rs2Val <= (rs2Sel == '0) ? '0 : regs[rs2Sel];
      end
   end

   // Index routed from the fetched word must match the decoded one
   x0ReadsZero: assert property (@(posedge clk)
      regRead |=> ((ops.rs1Idx != '0) || (ops.rs1Val == '0)) &&
                  ((ops.rs2Idx != '0) || (ops.rs2Val == '0)))
      else $error("x0 operand read back nonzero");

endmodule

//--- design/aluBranch.sv
/*
 * ALU and branch predicate
 * One 33-bit subtractor for SUB, SLT(U) and compares,
 * one right shifter that also does left shifts by bit reversal
 */
`timescale 1ns/1ps

module aluBranch
   import coreTypesPkg::*, rvIsaPkg::*;
(
   operandIf.exec ops,
   output wordT   aluOut,
   output wordT   aluSum,     // Also the JALR target
   output logic   takeBranch
);
   wordT               in1;
   wordT               in2;
   logic [32:0]        diff;
   logic               lt;
   logic               ltu;
   logic               eq;
   logic               isLeft;
   logic signed [32:0] shIn;
   logic [32:0]        shFull;
   aluFnT              aluFn;
   branchFnT           brFn;

   function automatic wordT bitRev(input wordT w);
      wordT r;
      for (int i = 0; i < $bits(wordT); i++) begin
         r[i] = w[$bits(wordT)-1-i];
      end
      return r;
   endfunction

   assign aluFn = aluFnT'(ops.funct3);
   assign brFn  = branchFnT'(ops.funct3);

   assign in1 = ops.rs1Val;
   assign in2 = ((ops.opcode == op) || (ops.opcode == branch)) ? ops.rs2Val : ops.imm;

   assign aluSum = in1 + in2;
   assign diff   = {1'b0, in1} - {1'b0, in2};  // Bit 32 is the borrow
   assign ltu    = diff[32];
   assign lt     = (in1[31] ^ in2[31]) ? in1[31] : diff[32];  // Signs differ, rs1 sign decides
   assign eq     = (diff[31:0] == '0);

   // Sign bit only fed in for SRA/SRAI
   assign isLeft = (aluFn == aluSll);
   assign shIn   = {ops.altFn & in1[31], isLeft ? bitRev(in1) : in1};
   assign shFull = shIn >>> in2[4:0];

   always_comb begin
      case (aluFn)
         aluAdd:  aluOut = (ops.altFn && (ops.opcode == op)) ? diff[31:0] : aluSum;  // ADDI never subtracts
         aluSll:  aluOut = bitRev(shFull[31:0]);
         aluSlt:  aluOut = {31'b0, lt};
         aluSltu: aluOut = {31'b0, ltu};
         aluXor:  aluOut = in1 ^ in2;
         aluSr:   aluOut = shFull[31:0];
         aluOr:   aluOut = in1 | in2;
         aluAnd:  aluOut = in1 & in2;
      endcase
   end

   // Predicate only, gated by opcode in control
   always_comb begin
      case (brFn)
         brEq:    takeBranch = eq;
         brNe:    takeBranch = !eq;
         brLt:    takeBranch = lt;
         brGe:    takeBranch = !lt;
         brLtu:   takeBranch = ltu;
         brGeu:   takeBranch = !ltu;
         default: takeBranch = 1'b0;  // Undefined funct3
      endcase
   end

endmodule

//--- design/loadStoreUnit.sv
/*
 * Load/store unit
 * Address adder, load lane select with sign extension,
 * store lane replication and byte write mask
 */
`timescale 1ns/1ps

module loadStoreUnit
   import coreTypesPkg::*, rvIsaPkg::*;
(
   operandIf.exec     ops,
   input  wordT       memRdata,
   output wordT       lsAddr,
   output wordT       loadData,
   output wordT       storeData,
   output logic [3:0] storeMask  // Gated into memWmask by control
);
   memWidthT    width;
   logic [15:0] loadHalf;
   logic [7:0]  loadByte;
   logic        loadSign;

   assign width  = memWidthT'(ops.funct3[1:0]);
   assign lsAddr = ops.rs1Val + ops.imm;  // I for loads, S for stores

   // Lane select by low address bits
   assign loadHalf = lsAddr[1] ? memRdata[31:16] : memRdata[15:0];
   assign loadByte = lsAddr[0] ? loadHalf[15:8] : loadHalf[7:0];
   assign loadSign = !ops.funct3[2] & ((width == memByte) ? loadByte[7] : loadHalf[15]);  // LBU/LHU zero

   always_comb begin
      case (width)
         memByte: loadData = {{24{loadSign}}, loadByte};
         memHalf: loadData = {{16{loadSign}}, loadHalf};
         default: loadData = memRdata;
      endcase
   end

   // rs2 copied into every lane the access can land on
   assign storeData[7:0]   = ops.rs2Val[7:0];
   assign storeData[15:8]  = lsAddr[0] ? ops.rs2Val[7:0] : ops.rs2Val[15:8];
   assign storeData[23:16] = lsAddr[1] ? ops.rs2Val[7:0] : ops.rs2Val[23:16];
   assign storeData[31:24] = lsAddr[0] ? ops.rs2Val[7:0] :
                             lsAddr[1] ? ops.rs2Val[15:8] : ops.rs2Val[31:24];

   always_comb begin
      case (width)
         memByte: storeMask = 4'b0001 << lsAddr[1:0];  // One-hot byte
         memHalf: storeMask = lsAddr[1] ? 4'b1100 : 4'b0011;
         default: storeMask = 4'b1111;
      endcase
   end

endmodule

//--- design/coreControl.sv
/*
 * Core control
 * Multicycle FSM, program counter, instruction register,
 * next-PC select, write-back mux and memory strobes
 */
`timescale 1ns/1ps
`include "coreSettings.svh"

module coreControl
   import coreTypesPkg::*, rvIsaPkg::*;
(
   input  logic       clk,
   input  logic       reset,      // Active low
   input  wordT       memRdata,
   input  logic       memRbusy,
   input  logic       memWbusy,
   operandIf.ctrl     ops,
   input  wordT       aluOut,
   input  wordT       aluSum,
   input  wordT       lsAddr,
   input  wordT       loadData,
   input  logic [3:0] storeMask,
   input  logic       takeBranch,
   output wordT       instr,
   output regIdxT     rs1Sel,
   output regIdxT     rs2Sel,
   output logic       regRead,
   output logic       wbEn,
   output wordT       wbData,
   output wordT       memAddr,
   output logic       memRstrb,
   output logic [3:0] memWmask
);
   localparam wordT nopInstr = 32'h0000_0013;  // addi x0, x0, 0

   coreStateT state;
   wordT      pc;
   wordT      pcPlus4;    // Also the link address
   wordT      pcPlusImm;  // JAL, branch and AUIPC
   wordT      pcNext;
   logic      memIdle;

   assign pcPlus4   = pc + 32'd4;
   assign pcPlusImm = pc + ops.imm;
   assign memIdle   = !memRbusy && !memWbusy;

   always_comb begin
      case (ops.opcode)
         jal:     pcNext = pcPlusImm;
         branch:  pcNext = takeBranch ? pcPlusImm : pcPlus4;
         jalr:    pcNext = {aluSum[`CORE_XLEN-1:1], 1'b0};
         default: pcNext = pcPlus4;
      endcase
   end

   always_comb begin
      case (ops.opcode)
         lui:       wbData = ops.imm;
         auipc:     wbData = pcPlusImm;
         jal, jalr: wbData = pcPlus4;
         load:      wbData = loadData;
         default:   wbData = aluOut;
      endcase
   end

   // Loads write back in the last waitMem cycle, the rest in execute
   assign wbEn = ((state == execute) && (ops.opcode inside {op, opImm, lui, auipc, jal, jalr})) ||
                 ((state == waitMem) && (ops.opcode == load) && memIdle);

   // Operand indices straight from the word being fetched
   assign regRead = (state == waitInstr) && !memRbusy;
   assign rs1Sel  = memRdata[19:15];
   assign rs2Sel  = memRdata[24:20];

   assign memAddr  = ((state == fetchInstr) || (state == waitInstr)) ? pc : lsAddr;
   assign memRstrb = (state == fetchInstr) || ((state == execute) && (ops.opcode == load));
   assign memWmask = ((state == execute) && (ops.opcode == store)) ? storeMask : 4'b0000;

   always_ff @(posedge clk) begin
      if (!reset) begin
         state <= waitMem;  // Wait for memory idle before first fetch
         pc    <= `CORE_RESET_ADDR;
         instr <= nopInstr;
      end else begin
         case (state)
            fetchInstr: state <= waitInstr;
            waitInstr: begin
               if (!memRbusy) begin
                  instr <= memRdata;
                  state <= execute;
               end
            end
            execute: begin
               pc    <= pcNext;
               state <= ((ops.opcode == load) || (ops.opcode == store)) ? waitMem : fetchInstr;
            end
            waitMem: begin
               if (memIdle) state <= fetchInstr;
            end
         endcase
      end
   end

   // Accesses start only on an idle bus and never read and write at once
   rdWrExclusive: assert property (@(posedge clk) disable iff (!reset)
      (memRstrb || (memWmask != 4'b0000)) |->
         memIdle && !(memRstrb && (memWmask != 4'b0000)))
      else $error("Memory access started while busy or as read and write together");

   stateLegal: assert property (@(posedge clk) disable iff (!reset)
      !$isunknown(state) && (state inside {fetchInstr, waitInstr, execute, waitMem}))
      else $error("Control state illegal");

endmodule

//--- design/femtoCore.sv
/*
 * RV32I multicycle core, top level
 * Word-wide memory port with read strobe, write mask and busy flags
 */
`timescale 1ns/1ps

module femtoCore
   import coreTypesPkg::*;
(
   input  logic       clk,
   input  logic       reset,     // Synchronous, active low
   output wordT       memAddr,
   output wordT       memWdata,
   output logic [3:0] memWmask,  // Byte lanes, nonzero starts a write
   output logic       memRstrb,  // Starts a read
   input  wordT       memRdata,
   input  logic       memRbusy,
   input  logic       memWbusy
);
   wordT       instr;
   regIdxT     rs1Sel;
   regIdxT     rs2Sel;
   logic       regRead;
   logic       wbEn;
   wordT       wbData;
   wordT       aluOut;
   wordT       aluSum;
   logic       takeBranch;
   wordT       lsAddr;
   wordT       loadData;
   logic [3:0] storeMask;

   operandIf ops ();

   instrDecoder decoder (.instr(instr), .ops(ops.decode));

   regFile regs (
      .clk(clk), .regRead(regRead), .rs1Sel(rs1Sel), .rs2Sel(rs2Sel),
      .wbEn(wbEn), .wbData(wbData), .ops(ops.regs)
   );

   aluBranch alu (.ops(ops.exec), .aluOut(aluOut), .aluSum(aluSum), .takeBranch(takeBranch));

   // Store data goes straight to the bus
   loadStoreUnit lsu (
      .ops(ops.exec), .memRdata(memRdata), .lsAddr(lsAddr), .loadData(loadData),
      .storeData(memWdata), .storeMask(storeMask)
   );

   coreControl ctrl (
      .clk(clk), .reset(reset), .memRdata(memRdata), .memRbusy(memRbusy),
      .memWbusy(memWbusy), .ops(ops.ctrl), .aluOut(aluOut), .aluSum(aluSum),
      .lsAddr(lsAddr), .loadData(loadData), .storeMask(storeMask),
      .takeBranch(takeBranch), .instr(instr), .rs1Sel(rs1Sel), .rs2Sel(rs2Sel),
      .regRead(regRead), .wbEn(wbEn), .wbData(wbData), .memAddr(memAddr),
      .memRstrb(memRstrb), .memWmask(memWmask)
   );

endmodule

//--- tests/coreTb.sv
/*
 * Testbench for the RV32I core
 * Word memory model with random busy cycles, store checking
 * against golden records, done address and watchdog
 */
`timescale 1ns/1ps

module coreTb
   import coreTypesPkg::*;
();
   localparam int memWords = 256;   // 1 KiB model
   localparam int countIdx = 'h80;  // Expected store count
   localparam int doneIdx  = 'h81;  // Done address
   localparam int progIdx  = 'h82;  // Program length in words
   localparam int recIdx   = 'h83;  // Records of address, data, mask

   logic       clk;
   logic       reset;
   wordT       memAddr;
   wordT       memWdata;
   logic [3:0] memWmask;
   logic       memRstrb;
   wordT       memRdata;
   logic       memRbusy;
   logic       memWbusy;

   wordT        mem [memWords];
   wordT        golden [memWords];  // Read-only image for records and limits
   int          storeCount;     // Stores checked so far
   int          rdCnt;          // Remaining read busy cycles
   int          wrCnt;
   logic        seenFetch;
   logic        resetApplied;   // First reset edge taken
   logic        doneSeen;

   femtoCore UUT (
      .clk(clk), .reset(reset), .memAddr(memAddr), .memWdata(memWdata),
      .memWmask(memWmask), .memRstrb(memRstrb), .memRdata(memRdata),
      .memRbusy(memRbusy), .memWbusy(memWbusy)
   );

   always #4 clk = ~clk;  // 8 ns period

   task automatic checkWord(input string name, input wordT expVal, input wordT actVal);
      if (expVal !== actVal) begin
         $display("ERR %0t %s expected %h actual %h", $time, name, expVal, actVal);
         $display("Simulation failed");
         $fatal(1);
      end
   endtask

   task automatic checkMask(input string name, input logic [3:0] expVal,
                            input logic [3:0] actVal);
      if (expVal !== actVal) begin
         $display("ERR %0t %s expected %h actual %h", $time, name, expVal, actVal);
         $display("Simulation failed");
         $fatal(1);
      end
   endtask

   task automatic checkBit(input string name, input logic expVal, input logic actVal);
      if (expVal !== actVal) begin
         $display("ERR %0t %s expected %b actual %b", $time, name, expVal, actVal);
         $display("Simulation failed");
         $fatal(1);
      end
   endtask

   // Byte lanes enabled by a write mask
   function automatic wordT laneBits(input logic [3:0] mask);
      return {{8{mask[3]}}, {8{mask[2]}}, {8{mask[1]}}, {8{mask[0]}}};
   endfunction

   // Compare one store against the next golden record, or flag the done store
   task automatic compareStore();
      int   base;
      wordT expMask;
      if (memAddr == golden[doneIdx]) begin
         doneSeen = 1'b1;
      end else if (storeCount >= int'(golden[countIdx])) begin
         $display("More stores than expected, extra store to %h", memAddr);
         $display("Simulation failed");
         $fatal(1);
      end else begin
         base    = recIdx + 3 * storeCount;
         expMask = golden[base+2];
         checkWord("memAddr", golden[base], memAddr);
         checkMask("memWmask", expMask[3:0], memWmask);
         checkWord("memWdata", golden[base+1] & laneBits(expMask[3:0]),  // Only addressed lanes
                   memWdata & laneBits(expMask[3:0]));
         storeCount++;
      end
   endtask

   // Memory model, busy flags and data driven on the rising edge
   initial begin
      memRdata     = '0;
      memRbusy     = 1'b0;
      memWbusy     = 1'b0;
      rdCnt        = 0;
      wrCnt        = 0;
      storeCount   = 0;
      seenFetch    = 1'b0;
      resetApplied = 1'b0;
      doneSeen     = 1'b0;
      void'($urandom(32'haf0e_2352));  // One seed for all busy lengths
      forever begin
         @(posedge clk);
         if (!reset) begin
            if (resetApplied) begin  // Outputs defined after the first reset edge
               checkMask("memWmask", 4'b0000, memWmask);  // Quiet bus in reset
               checkBit("memRstrb", 1'b0, memRstrb);
            end
            resetApplied = 1'b1;
            rdCnt = 0;
            wrCnt = 0;
            memRbusy <= 1'b0;
            memWbusy <= 1'b0;
         end else begin
            if (rdCnt > 0) rdCnt--;
            if (wrCnt > 0) wrCnt--;
            if (memRstrb) begin
               if (!seenFetch) begin
                  checkWord("memAddr", 32'h0000_0000, memAddr);  // First fetch at reset vector
                  seenFetch = 1'b1;
               end
               memRdata <= mem[memAddr[9:2]];
               rdCnt = $urandom % 3;
            end
            if (memWmask != 4'b0000) begin
               compareStore();
               for (int b = 0; b < 4; b++) begin
                  if (memWmask[b]) mem[memAddr[9:2]][8*b +: 8] = memWdata[8*b +: 8];
               end
               wrCnt = $urandom % 3;
            end
            memRbusy <= (rdCnt != 0);
            memWbusy <= (wrCnt != 0);
         end
      end
   end

   initial begin
      clk   = 1'b0;
      reset = 1'b0;
      $readmemh("tests/coreGolden.hex", mem);
      $readmemh("tests/coreGolden.hex", golden);
      repeat (10) @(posedge clk);
      reset <= 1'b1;
      wait (doneSeen);
      if (storeCount == int'(golden[countIdx])) begin
         $display("Simulation completed successfully");
         $finish;
      end else begin
         $display("Done reached after %0d of %0d expected stores",
                  storeCount, golden[countIdx]);
         $display("Simulation failed");
         $fatal(1);
      end
   end

   // Watchdog, 40 cycles per program word
   initial begin
      #1;
      repeat (40 * int'(golden[progIdx]) + 10) @(posedge clk);
      $display("Timeout, done address never written");
      $display("Simulation failed");
      $fatal(1);
   end

endmodule

//--- tests/coreGolden.hex
// Words 000-059: program, 080: store count, 081: done address, 082: program words
// Records from 083, columns: store address, lane data, byte mask. Word 0FC: load data
@000
30000093 FF800113 00500193          // x1=0x300 x2=-8 x3=5
00310233 0040A023 40310233 0040A223 // add sub
00312233 0040A423 00313233 0040A623 // slt sltu
00314233 0040A823 00316233 0040AA23 // xor or
00317233 0040AC23 00311233 0040AE23 // and sll
00315233 0240A023 40315233 0240A223 // srl sra
12345237 0240A423 00001217 0240A623 // lui auipc
0F008283 0250A823 0F108283 0250AA23 // lb lanes 0 1
0F208283 0250AC23 0F308283 0250AE23 // lb lanes 2 3
0F00C283 0450A023 0F30C283 0450A223 // lbu lanes 0 3
0F009283 0450A423 0F209283 0450A623 // lh lanes 0 2
0F20D283 0450A823                   // lhu lane 2
A1B2C337 3D430313                   // x6=0xA1B2C3D4
06608023 066080A3 06608123 066081A3 // sb each offset
06609223 06609323 0660A423          // sh both halves, sw
00000393                            // x7=0
00318463 00138393 00310463 00238393 // beq taken, not taken
00311463 00438393 00319463 00838393 // bne
00314463 01038393 0021C463 02038393 // blt
0021D463 04038393 00315463 08038393 // bge
0021E463 10038393 00316463 20038393 // bltu
00317463 40038393 0021F463 80038393 // bgeu
0670A623                            // store branch markers
0080046F 00000413 0680A823          // jal x8 and store link
15D00493 00048567 00000513 00000513 06A0AA23 // jalr x10 and store link
0E00AE23 0000006F                   // done store, spin
@080
0000001F 000003FC 0000005A
00000300 FFFFFFFD 0000000F
00000304 FFFFFFF3 0000000F
00000308 00000001 0000000F
0000030C 00000000 0000000F
00000310 FFFFFFFD 0000000F
00000314 FFFFFFFD 0000000F
00000318 00000000 0000000F
0000031C FFFFFF00 0000000F
00000320 07FFFFFF 0000000F
00000324 FFFFFFFF 0000000F
00000328 12345000 0000000F
0000032C 00001064 0000000F
00000330 FFFFFF80 0000000F
00000334 0000007F 0000000F
00000338 00000012 0000000F
0000033C FFFFFFF3 0000000F
00000340 00000080 0000000F
00000344 000000F3 0000000F
00000348 00007F80 0000000F
0000034C FFFFF312 0000000F
00000350 0000F312 0000000F
00000360 000000D4 00000001
00000361 0000D400 00000002
00000362 00D40000 00000004
00000363 D4000000 00000008
00000364 0000C3D4 00000003
00000366 C3D40000 0000000C
00000368 A1B2C3D4 0000000F
0000036C FFFFFAAA 0000000F
00000370 00000144 0000000F
00000374 00000154 0000000F
@0FC
F3127F80

//--- sim.f
+incdir+include
design/rvIsaPkg.sv
design/coreTypesPkg.sv
design/operandIf.sv
design/instrDecoder.sv
design/regFile.sv
design/aluBranch.sv
design/loadStoreUnit.sv
design/coreControl.sv
design/femtoCore.sv
tests/coreTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= coreTb
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

SRCS    := $(filter-out +%,$(shell cat sim.f))
HEADERS := include/coreSettings.svh
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): sim.f $(SRCS) $(HEADERS)
	$(VERILATOR) $(VFLAGS) -f sim.f --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BIN) tests/coreGolden.hex
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)
